//--- verilog/uart_pkg.sv
`default_nettype none

package uart_pkg;

    // bus geometry
    localparam int word_width = 32;
    localparam int addr_width = 8;

    // serial timing, short for simulation
    localparam int bit_cycles = 16;   // clocks per serial bit
    localparam int data_bits  = 8;

    // receive FIFO
    localparam int fifo_depth = 4;
    localparam int fifo_aw    = 2;    // count is fifo_aw+1 bits wide

    // register offsets
    localparam logic [addr_width-1:0] addr_rxdata = 8'h00;
    localparam logic [addr_width-1:0] addr_status = 8'h04;
    localparam logic [addr_width-1:0] addr_ctrl   = 8'h08;

    // AHB-lite codes
    localparam logic [1:0] htrans_nonseq = 2'b10;
    localparam logic       hresp_okay    = 1'b0;
    localparam logic       hresp_error   = 1'b1;

    // status bits, FIFO count sits at 6:4
    localparam int st_not_empty = 0;
    localparam int st_overrun   = 1;
    localparam int st_frame_err = 2;

    // control bits
    localparam int ctrl_irq_en      = 0;
    localparam int ctrl_clr_overrun = 1;   // write one to clear
    localparam int ctrl_clr_frame   = 2;   // write one to clear

    localparam int rxdata_perr_bit = 8;

    typedef struct packed {
        logic                 parity_err;
        logic [data_bits-1:0] data;
    } rx_entry_t;

endpackage

`default_nettype wire

//--- verilog/uart_bit_timer.sv
`timescale 1ns/10ps
`default_nettype none

module uart_bit_timer (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  bit_run,
    output logic sample_stb,
    output logic bit_end
);

    logic [$clog2(uart_pkg::bit_cycles)-1:0] cnt;

    // free-running bit counter, held at zero while idle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (!bit_run) begin
            cnt <= '0;
        end else if (cnt == uart_pkg::bit_cycles - 1) begin
            cnt <= '0;   // wrap at end of bit
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // mid-bit sample point
    assign sample_stb = bit_run && (cnt == uart_pkg::bit_cycles / 2);

    // last clock of the bit period
    assign bit_end = bit_run && (cnt == uart_pkg::bit_cycles - 1);

endmodule

`default_nettype wire

//--- verilog/uart_rx_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module uart_rx_fsm (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 rx,
    input  wire                 sample_stb,
    input  wire                 bit_end,
    output logic                bit_run,
    input  wire                 full,
    output logic                push,
    output uart_pkg::rx_entry_t push_entry,
    output logic                overrun_evt,
    output logic                frame_err_evt
);

    typedef enum logic [2:0] {s_idle, s_start, s_data, s_parity, s_stop} state_t;

    state_t                                 state;
    logic                                   rx_s1, rx_s2, rx_prev;
    logic                                   fall;
    logic                                   stop_smp;
    logic [$clog2(uart_pkg::data_bits)-1:0] bit_idx;
    logic [uart_pkg::data_bits-1:0]         shift_q;
    logic                                   par_acc;
    logic                                   perr_q;

    assign fall = rx_prev && !rx_s2;   // start edge

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_s1   <= 1'b1;   // line idles high
            rx_s2   <= 1'b1;
            rx_prev <= 1'b1;
            state   <= s_idle;
            bit_idx <= '0;
        end else begin
            rx_s1   <= rx;
            rx_s2   <= rx_s1;
            rx_prev <= rx_s2;
            case (state)
                s_idle: if (fall) state <= s_start;
                s_start: begin
                    if (sample_stb && rx_s2) begin
                        state <= s_idle;   // glitch, not a real start bit
                    end else if (bit_end) begin
                        state   <= s_data;
                        bit_idx <= '0;
                    end
                end
                s_data: begin
                    if (bit_end) begin
                        if (bit_idx == uart_pkg::data_bits - 1) state <= s_parity;
                        else bit_idx <= bit_idx + 1'b1;
                    end
                end
                s_parity: if (bit_end) state <= s_stop;
                s_stop: if (sample_stb) state <= s_idle;
                default: state <= s_idle;
            endcase
        end
    end

    // datapath, lsb first
    always_ff @(posedge clk) begin
        if (state == s_start) par_acc <= 1'b0;
        if (state == s_data && sample_stb) begin
            shift_q <= {rx_s2, shift_q[uart_pkg::data_bits-1:1]};
            par_acc <= par_acc ^ rx_s2;
        end
        if (state == s_parity && sample_stb) perr_q <= par_acc ^ rx_s2;   // even parity check
    end

    assign bit_run  = (state != s_idle);
    assign stop_smp = (state == s_stop) && sample_stb;

    assign push          = stop_smp && rx_s2 && !full;
    assign overrun_evt   = stop_smp && rx_s2 && full;   // byte dropped
    assign frame_err_evt = stop_smp && !rx_s2;

    always_comb begin
        push_entry.data       = shift_q;
        push_entry.parity_err = perr_q;
    end

endmodule

`default_nettype wire

//--- verilog/uart_rx_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module uart_rx_fifo #(
    parameter type payload_t = logic [7:0]
) (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        push,
    input  wire payload_t              push_data,
    input  wire                        pop,
    output payload_t                   pop_data,
    output logic                       empty,
    output logic                       full,
    output logic [uart_pkg::fifo_aw:0] count
);

    payload_t                       mem [uart_pkg::fifo_depth];
    logic [uart_pkg::fifo_aw-1:0]   wr_ptr;
    logic [uart_pkg::fifo_aw-1:0]   rd_ptr;
    logic                           do_push;
    logic                           do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            if (do_push && !do_pop) count <= count + 1'b1;
            else if (do_pop && !do_push) count <= count - 1'b1;
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= push_data;
    end

    assign pop_data = mem[rd_ptr];   // head entry, shown without a pop
    assign empty    = (count == '0);
    assign full     = (count == (uart_pkg::fifo_aw + 1)'(uart_pkg::fifo_depth));

endmodule

`default_nettype wire

//--- verilog/uart_ahb_regs.sv
`timescale 1ns/10ps
`default_nettype none

module uart_ahb_regs (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire                             hsel,
    input  wire [uart_pkg::addr_width-1:0]  haddr,
    input  wire                             hwrite,
    input  wire [1:0]                       htrans,
    input  wire [uart_pkg::word_width-1:0]  hwdata,
    output logic [uart_pkg::word_width-1:0] hrdata,
    output logic                            hready,
    output logic                            hresp,
    output logic                            pop,
    input  wire uart_pkg::rx_entry_t        pop_entry,
    input  wire                             empty,
    input  wire [uart_pkg::fifo_aw:0]       count,
    input  wire                             overrun_evt,
    input  wire                             frame_err_evt,
    output logic                            irq
);

    logic                            accept;
    logic                            dp_valid;
    logic                            dp_write;
    logic [uart_pkg::addr_width-1:0] dp_addr;
    logic                            dp_err;
    logic                            err2;
    logic                            ctrl_wr;
    logic                            mapped;
    logic                            irq_en;
    logic                            overrun_q;
    logic                            frame_q;
    logic [uart_pkg::word_width-1:0] rd_word;

    // address phase, only taken while the bus is ready
    assign accept = hsel && (htrans == uart_pkg::htrans_nonseq) && hready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dp_valid <= 1'b0;
            dp_write <= 1'b0;
            dp_addr  <= '0;
            err2     <= 1'b0;
        end else begin
            dp_valid <= accept;
            if (accept) begin
                dp_write <= hwrite;
                dp_addr  <= haddr;
            end
            err2 <= dp_err;   // second error cycle
        end
    end

    assign mapped  = (dp_addr == uart_pkg::addr_rxdata) || (dp_addr == uart_pkg::addr_status)
                     || (dp_addr == uart_pkg::addr_ctrl);
    assign dp_err  = dp_valid && (!mapped || (dp_write && dp_addr != uart_pkg::addr_ctrl));
    assign ctrl_wr = dp_valid && dp_write && (dp_addr == uart_pkg::addr_ctrl);

    assign hready = !dp_err;
    assign hresp  = (dp_err || err2) ? uart_pkg::hresp_error : uart_pkg::hresp_okay;

    // rxdata read pops in the data phase
    assign pop = dp_valid && !dp_write && (dp_addr == uart_pkg::addr_rxdata) && !empty;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            irq_en    <= 1'b0;
            overrun_q <= 1'b0;
            frame_q   <= 1'b0;
            irq       <= 1'b0;
        end else begin
            if (ctrl_wr) irq_en <= hwdata[uart_pkg::ctrl_irq_en];
            // new events win over a clear in the same cycle
            overrun_q <= overrun_evt
                         || (overrun_q && !(ctrl_wr && hwdata[uart_pkg::ctrl_clr_overrun]));
            frame_q   <= frame_err_evt
                         || (frame_q && !(ctrl_wr && hwdata[uart_pkg::ctrl_clr_frame]));
            irq       <= !empty && irq_en && !(pop && count == 'd1);   // drops with the last pop
        end
    end

    always_comb begin
        rd_word = '0;
        case (dp_addr)
            uart_pkg::addr_rxdata: begin
                if (!empty) begin   // empty fifo reads as zero
                    rd_word[uart_pkg::data_bits-1:0]  = pop_entry.data;
                    rd_word[uart_pkg::rxdata_perr_bit] = pop_entry.parity_err;
                end
            end
            uart_pkg::addr_status: begin
                rd_word[uart_pkg::st_not_empty]     = !empty;
                rd_word[uart_pkg::st_overrun]       = overrun_q;
                rd_word[uart_pkg::st_frame_err]     = frame_q;
                rd_word[4 +: uart_pkg::fifo_aw + 1] = count;   // bits 6:4
            end
            uart_pkg::addr_ctrl: rd_word[uart_pkg::ctrl_irq_en] = irq_en;
            default: rd_word = '0;
        endcase
    end

    assign hrdata = (dp_valid && !dp_write) ? rd_word : '0;

endmodule

`default_nettype wire

//--- verilog/uart_rx_top.sv
`timescale 1ns/10ps
`default_nettype none

module uart_rx_top (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire                             rx,
    input  wire                             hsel,
    input  wire [uart_pkg::addr_width-1:0]  haddr,
    input  wire                             hwrite,
    input  wire [1:0]                       htrans,
    input  wire [uart_pkg::word_width-1:0]  hwdata,
    output logic [uart_pkg::word_width-1:0] hrdata,
    output logic                            hready,
    output logic                            hresp,
    output logic                            irq
);

    logic                       bit_run, sample_stb, bit_end;
    logic                       push, pop, full, empty;
    logic                       overrun_evt, frame_err_evt;
    uart_pkg::rx_entry_t        push_entry, pop_entry;
    logic [uart_pkg::fifo_aw:0] count;

    uart_bit_timer u_bit_timer (
        .clk, .rst_n, .bit_run, .sample_stb, .bit_end
    );

    uart_rx_fsm u_rx_fsm (
        .clk, .rst_n, .rx, .sample_stb, .bit_end, .bit_run, .full,
        .push, .push_entry, .overrun_evt, .frame_err_evt
    );

    uart_rx_fifo #(
        .payload_t (uart_pkg::rx_entry_t)
    ) u_rx_fifo (
        .clk, .rst_n, .push, .push_data (push_entry), .pop, .pop_data (pop_entry),
        .empty, .full, .count
    );

    uart_ahb_regs u_ahb_regs (
        .clk, .rst_n, .hsel, .haddr, .hwrite, .htrans, .hwdata, .hrdata, .hready, .hresp,
        .pop, .pop_entry, .empty, .count, .overrun_evt, .frame_err_evt, .irq
    );

endmodule

`default_nettype wire

//--- testbench/uart_rx_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module uart_rx_asserts (
    input wire                       clk,
    input wire                       rst_n,
    input wire                       hready,
    input wire                       hresp,
    input wire                       irq,
    input wire                       empty,
    input wire [uart_pkg::fifo_aw:0] count
);

    int fail_cnt = 0;   // assertion failures so far

    // error response, low-ready cycle then high-ready cycle, then okay
    a_err_first: assert property (@(posedge clk) disable iff (!rst_n)
        (hresp == uart_pkg::hresp_error && !hready) |=> (hresp == uart_pkg::hresp_error && hready))
        else begin
            fail_cnt++;
            $error("error response second cycle missing");
        end

    a_err_second: assert property (@(posedge clk) disable iff (!rst_n)
        (hresp == uart_pkg::hresp_error && hready) |=> (hresp == uart_pkg::hresp_okay))
        else begin
            fail_cnt++;
            $error("error response longer than two cycles");
        end

    a_err_start: assert property (@(posedge clk) disable iff (!rst_n)
        (hresp == uart_pkg::hresp_error && hready) |-> $past(!hready))
        else begin
            fail_cnt++;
            $error("error response did not start with hready low");
        end

    a_count_max: assert property (@(posedge clk) disable iff (!rst_n)
        count <= uart_pkg::fifo_depth)
        else begin
            fail_cnt++;
            $error("fifo count above depth");
        end

    a_irq_data: assert property (@(posedge clk) disable iff (!rst_n) irq |-> !empty)
        else begin
            fail_cnt++;
            $error("irq high with an empty fifo");
        end

endmodule

`default_nettype wire

//--- testbench/uart_rx_tb.sv
`timescale 1ns/10ps
`default_nettype none

module uart_rx_tb;

    logic                             clk;
    logic                             rst_n;
    logic                             rx;
    logic                             hsel;
    logic [uart_pkg::addr_width-1:0]  haddr;
    logic                             hwrite;
    logic [1:0]                       htrans;
    logic [uart_pkg::word_width-1:0]  hwdata;
    logic [uart_pkg::word_width-1:0]  hrdata;
    logic                             hready;
    logic                             hresp;
    logic                             irq;

    // one entry per operation line of the pattern file
    logic [3:0]  op_q[$];
    logic [7:0]  val_q[$];
    logic [3:0]  flg_q[$];
    logic [31:0] word_q[$];
    int          n_ops = 0;
    int          cur_op = 0;

    uart_rx_top u_uart_rx_top (
        .clk, .rst_n, .rx, .hsel, .haddr, .hwrite, .htrans, .hwdata,
        .hrdata, .hready, .hresp, .irq
    );

    bind uart_rx_top uart_rx_asserts u_asserts (
        .clk (clk), .rst_n (rst_n), .hready (hready), .hresp (hresp),
        .irq (irq), .empty (empty), .count (count)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;   // 100 ns period
    end

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("[FAIL] %s expected 0x%08h got 0x%08h (operation %0d)",
                                        name, expected, actual, cur_op));
        end
    endtask

    task automatic load_patterns();
        int          fd;
        int          got;
        string       line;
        logic [31:0] f_op, f_val, f_flg, f_word;
        fd = $fopen("testbench/uart_rx_patterns.txt", "r");
        if (fd == 0) stop_with_failure("could not open testbench/uart_rx_patterns.txt");
        while (!$feof(fd)) begin
            got = $fgets(line, fd);
            // comment lines fail the scan and are skipped
            if (got > 0 && $sscanf(line, "%h %h %h %h", f_op, f_val, f_flg, f_word) == 4) begin
                op_q.push_back(f_op[3:0]);
                val_q.push_back(f_val[7:0]);
                flg_q.push_back(f_flg[3:0]);
                word_q.push_back(f_word);
            end
        end
        $fclose(fd);
        n_ops = op_q.size();
    endtask

    // start, 8 data bits lsb first, even parity, stop
    task automatic send_frame(input logic [7:0] data, input logic bad_par, input logic low_stop);
        logic [10:0] bits;
        int          i;
        bits = {~low_stop, (^data) ^ bad_par, data, 1'b0};
        for (i = 0; i < 11; i++) begin
            @(posedge clk);
            rx <= bits[i];
            repeat (uart_pkg::bit_cycles - 1) @(posedge clk);
        end
        @(posedge clk);
        rx <= 1'b1;   // back to idle
        repeat (4) @(posedge clk);
    endtask

    task automatic addr_phase(input logic [7:0] addr, input logic wr);
        @(posedge clk);
        hsel   <= 1'b1;
        haddr  <= addr;
        hwrite <= wr;
        htrans <= uart_pkg::htrans_nonseq;
    endtask

    task automatic bus_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic rdy, output logic resp);
        addr_phase(addr, 1'b0);
        @(posedge clk);
        hsel   <= 1'b0;
        htrans <= 2'b00;
        @(negedge clk);   // data phase, outputs settled
        data = hrdata;
        rdy  = hready;
        resp = hresp;
    endtask

    task automatic bus_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic rdy, output logic resp);
        addr_phase(addr, 1'b1);
        @(posedge clk);
        hsel   <= 1'b0;
        htrans <= 2'b00;
        hwdata <= data;
        @(negedge clk);
        rdy  = hready;
        resp = hresp;
    endtask

    task automatic bus_error(input logic [7:0] addr, input logic wr);
        addr_phase(addr, wr);
        @(posedge clk);
        hsel   <= 1'b0;
        htrans <= 2'b00;
        hwdata <= '0;
        @(negedge clk);
        check_value("hready", 1'b0, hready);   // first error cycle stalls
        check_value("hresp", uart_pkg::hresp_error, hresp);
        @(negedge clk);
        check_value("hready", 1'b1, hready);
        check_value("hresp", uart_pkg::hresp_error, hresp);
    endtask

    task automatic check_irq(input logic expected);
        repeat (2) @(posedge clk);   // pop, then the registered irq
        @(negedge clk);
        check_value("irq", expected, irq);
    endtask

    initial begin : watchdog
        wait (n_ops > 0);
        repeat (n_ops * (11 * uart_pkg::bit_cycles + 40) + 20) @(posedge clk);
        stop_with_failure("timeout: the pattern run did not finish in time");
    end

    initial begin : assert_monitor
        wait (u_uart_rx_top.u_asserts.fail_cnt != 0);
        stop_with_failure("a bound assertion failed during the run");
    end

    initial begin : main
        logic [31:0] rdata;
        logic        rdy;
        logic        resp;
        rst_n  = 1'b0;
        rx     = 1'b1;
        hsel   = 1'b0;
        haddr  = '0;
        hwrite = 1'b0;
        htrans = 2'b00;
        hwdata = '0;
        load_patterns();
        if (n_ops == 0) stop_with_failure("the pattern file holds no operations");
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("hready", 1'b1, hready);
        check_value("hresp", uart_pkg::hresp_okay, hresp);
        check_value("hrdata", '0, hrdata);
        check_value("irq", 1'b0, irq);
        for (cur_op = 0; cur_op < n_ops; cur_op++) begin
            case (op_q[cur_op])
                4'h1: send_frame(val_q[cur_op], flg_q[cur_op][0], flg_q[cur_op][1]);
                4'h2: begin
                    bus_read(val_q[cur_op], rdata, rdy, resp);
                    check_value("hready", 1'b1, rdy);
                    check_value("hresp", uart_pkg::hresp_okay, resp);
                    check_value("hrdata", word_q[cur_op], rdata);
                end
                4'h3: begin
                    bus_write(val_q[cur_op], word_q[cur_op], rdy, resp);
                    check_value("hready", 1'b1, rdy);
                    check_value("hresp", uart_pkg::hresp_okay, resp);
                end
                4'h4: bus_error(val_q[cur_op], flg_q[cur_op][0]);
                4'h5: check_irq(word_q[cur_op][0]);
                default: stop_with_failure($sformatf("unknown operation code %0h at line %0d",
                                                     op_q[cur_op], cur_op));
            endcase
        end
        repeat (2) @(posedge clk);
        if (u_uart_rx_top.u_asserts.fail_cnt == 0) begin
            $display("test passed");
            $finish;
        end else begin
            $display("%0d assertion failures during the run", u_uart_rx_top.u_asserts.fail_cnt);
            $display("test failed");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

//--- testbench/uart_rx_patterns.txt
# columns: op value flags word, all hex
# op 1 send byte (flags 1 bad parity, 2 low stop), 2 read addr expect word,
# op 3 write word to addr, 4 access addr expecting error (flags 1 write), 5 expect irq = word
1 a5 0 00000000
1 3c 0 00000000
2 04 0 00000021
2 00 0 000000a5
2 04 0 00000011
2 00 0 0000003c
2 04 0 00000000
1 5a 1 00000000
2 00 0 0000015a
1 81 2 00000000
2 04 0 00000004
3 08 0 00000004
2 04 0 00000000
1 11 0 00000000
1 22 0 00000000
1 33 0 00000000
1 44 0 00000000
1 55 0 00000000
2 04 0 00000043
2 00 0 00000011
2 00 0 00000022
2 00 0 00000033
2 00 0 00000044
3 08 0 00000002
2 04 0 00000000
4 00 1 00000000
4 0c 0 00000000
2 00 0 00000000
3 08 0 00000001
1 e7 0 00000000
5 00 0 00000001
2 00 0 000000e7
5 00 0 00000000
3 08 0 00000000
1 c3 0 00000000
5 00 0 00000000
2 00 0 000000c3

//--- all.f
verilog/uart_pkg.sv
verilog/uart_bit_timer.sv
verilog/uart_rx_fsm.sv
verilog/uart_rx_fifo.sv
verilog/uart_ahb_regs.sv
verilog/uart_rx_top.sv
testbench/uart_rx_asserts.sv
testbench/uart_rx_tb.sv

//--- Bender.yml
package:
  name: uart_rx

sources:
  - verilog/uart_pkg.sv
  - verilog/uart_bit_timer.sv
  - verilog/uart_rx_fsm.sv
  - verilog/uart_rx_fifo.sv
  - verilog/uart_ahb_regs.sv
  - verilog/uart_rx_top.sv
  - target: test
    files:
      - testbench/uart_rx_asserts.sv
      - testbench/uart_rx_tb.sv
